// File: Makefile
# Verilator build, run and lint for the eye-tracking report formatter

VERILATOR ?= verilator
TOP       ?= tb_eye_report
RTL_TOP   ?= eye_report_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps

RTL_FILES := $(shell grep '^logic/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "Run did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_FILES) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_eye_report.sv
// Testbench for eye_report_top: stimulus, expected byte streams and handshake checks

`timescale 1ns/1ps
`default_nettype none

module tb_eye_report;

    localparam int unsigned SEED       = 32'hb92b_753b;
    localparam int          WAIT_LIMIT = 4000;
    localparam int          QUIET_LEN  = 40;

    logic                   CLK = 1'b0;
    logic                   RST_N;
    logic                   out_sel;
    meas_pkg::meas_fields_t fields;
    logic                   trig;
    logic                   tx_busy;
    logic                   busy;
    logic                   de;
    char_pkg::byte_t        data;
    logic                   rx_strobe;
    char_pkg::byte_t        rx_data;

    char_pkg::byte_t        got_q[$];
    char_pkg::byte_t        exp_q[$];
    int                     errors;
    int                     timeouts;
    int                     reports;
    int                     de_episodes;
    logic                   de_q;
    logic                   tx_busy_q;
    char_pkg::byte_t        data_q;

    always #10 CLK = ~CLK;

    eye_report_top uut (
        .CLK     (CLK),
        .RST_N   (RST_N),
        .out_sel (out_sel),
        .fields  (fields),
        .trig    (trig),
        .tx_busy (tx_busy),
        .busy    (busy),
        .de      (de),
        .data    (data)
    );

    tx_busy_model tx_model (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .de        (de),
        .data      (data),
        .tx_busy   (tx_busy),
        .rx_strobe (rx_strobe),
        .rx_data   (rx_data)
    );

    task automatic show_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        $display("[FAIL] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic log_problem(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    // Upper-case hex, most significant digit first
    function automatic void push_hex(input logic [27:0] value, input int digits);
        string      hex_digits = "0123456789ABCDEF";
        logic [3:0] nib;
        for (int i = digits - 1; i >= 0; i--) begin
            nib = value[4*i +: 4];
            exp_q.push_back(hex_digits[nib]);
        end
    endfunction

    function automatic void build_expected(input meas_pkg::meas_fields_t f, input logic sel);
        exp_q.delete();
        push_hex(28'(f.sum_s), 5);
        push_hex(sel ? f.quot_sx : f.sum_sx, 7);
        push_hex(sel ? f.quot_sy : f.sum_sy, 7);
        exp_q.push_back(8'h0A);
    endfunction

    task automatic random_fields();
        fields.sum_s   = meas_pkg::sum_s_t'($urandom);
        fields.sum_sx  = meas_pkg::sum_xy_t'($urandom);
        fields.sum_sy  = meas_pkg::sum_xy_t'($urandom);
        fields.quot_sx = meas_pkg::sum_xy_t'($urandom);
        fields.quot_sy = meas_pkg::sum_xy_t'($urandom);
    endtask

    // ------------------------------------------------------------------------
    // Handshake monitor
    // ------------------------------------------------------------------------
    always @(posedge CLK) begin
        if (!RST_N) begin
            de_q      <= 1'b0;
            tx_busy_q <= 1'b0;
            data_q    <= 8'hFF;
        end else begin
            if (rx_strobe) begin
                got_q.push_back(rx_data);
                assert (de) else log_problem("transmitter took a byte without de");
            end
            if (de && !de_q) begin
                de_episodes++;
            end
            assert (!(de && !de_q && tx_busy)) else log_problem("de rose while tx_busy high");
            // Byte held until the transmitter answers
            if (de_q && !tx_busy_q) begin
                assert (de) else log_problem("de dropped before tx_busy rose");
                assert (data == data_q) else show_mismatch("data", 64'(data), 64'(data_q));
            end
            assert (busy || (!de && !tx_busy)) else log_problem("handshake outside a report");
            de_q      <= de;
            tx_busy_q <= tx_busy;
            data_q    <= data;
        end
    end

    // trig_mode 0 single pulse, 1 held high, 2 extra pulses during the report
    task automatic run_report(input logic sel, input int trig_mode);
        int cycles;
        random_fields();
        out_sel = sel;
        build_expected(fields, sel);
        got_q.delete();
        de_episodes = 0;
        trig = 1'b1;
        cycles = 0;
        while (!busy && cycles < WAIT_LIMIT) begin
            @(negedge CLK);
            cycles++;
            if (trig_mode == 0) trig = 1'b0;
        end
        if (!busy) begin
            timeouts++;
            log_problem("busy did not rise after the trigger");
        end
        cycles = 0;
        while (busy && cycles < WAIT_LIMIT) begin
            @(negedge CLK);
            cycles++;
            // Pulses stop before the line feed so none lands after busy falls
            if (trig_mode == 2 && got_q.size() < 19) trig = 1'($urandom % 2);
            else if (trig_mode != 1) trig = 1'b0;
        end
        if (busy) begin
            timeouts++;
            log_problem("busy did not fall at the end of the report");
        end
        for (int i = 0; i < QUIET_LEN; i++) begin
            @(negedge CLK);
            assert (!busy) else log_problem("report started without a fresh trigger edge");
        end
        trig = 1'b0;
        repeat (3) @(negedge CLK);
        assert (got_q.size() == exp_q.size())
            else show_mismatch("byte count", 64'(got_q.size()), 64'(exp_q.size()));
        assert (de_episodes == got_q.size())
            else show_mismatch("de episodes", 64'(de_episodes), 64'(got_q.size()));
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            assert (got_q[i] == exp_q[i])
                else show_mismatch($sformatf("data byte %0d", i), 64'(got_q[i]), 64'(exp_q[i]));
            if (i < exp_q.size() - 1) begin
                assert (got_q[i] inside {[8'h30:8'h39], [8'h41:8'h46]})
                    else log_problem($sformatf("byte %0d is not an upper-case hex digit", i));
            end
        end
        reports++;
    endtask

    initial begin
        void'($urandom(SEED));
        RST_N       = 1'b0;
        out_sel     = 1'b0;
        fields      = '0;
        trig        = 1'b0;
        errors      = 0;
        timeouts    = 0;
        reports     = 0;
        de_episodes = 0;
        repeat (16) @(negedge CLK);
        RST_N = 1'b1;

        // Idle outputs before any trigger
        repeat (4) @(negedge CLK);
        assert (busy == 1'b0) else show_mismatch("busy", 64'(busy), 64'(0));
        assert (de == 1'b0) else show_mismatch("de", 64'(de), 64'(0));
        assert (data == 8'hFF) else show_mismatch("data", 64'(data), 64'hFF);

        run_report(1'b0, 0);
        run_report(1'b1, 0);
        run_report(1'b0, 1);
        run_report(1'b1, 2);
        for (int n = 0; n < 6; n++) begin
            run_report(1'($urandom % 2), 0);
        end

        $display("Reports: %0d, errors: %0d, timeouts: %0d", reports, errors, timeouts);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tx_busy_model.sv
// tx_busy_model: UART transmitter stand-in with random busy length and byte capture

`timescale 1ns/1ps
`default_nettype none

module tx_busy_model (
    input  wire                  CLK,
    input  wire                  RST_N,
    input  wire                  de,
    input  wire char_pkg::byte_t data,
    output logic                 tx_busy,
    output logic                 rx_strobe,
    output char_pkg::byte_t      rx_data
);

    int unsigned accept_delay;
    int unsigned busy_len;

    // Outputs change on the falling edge only
    initial begin
        tx_busy   = 1'b0;
        rx_strobe = 1'b0;
        rx_data   = '0;
        forever begin
            @(negedge CLK);
            rx_strobe = 1'b0;
            if (RST_N && de) begin
                accept_delay = 1 + ($urandom % 4);
                busy_len     = 1 + ($urandom % 30);
                repeat (accept_delay) @(negedge CLK);
                // Byte taken at the busy rise
                tx_busy   = 1'b1;
                rx_data   = data;
                rx_strobe = 1'b1;
                @(negedge CLK);
                rx_strobe = 1'b0;
                repeat (busy_len - 1) @(negedge CLK);
                tx_busy = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/byte_sender.sv
// byte_sender: one byte at a time to the UART transmitter with busy handshake

`timescale 1ns/1ps
`default_nettype none

module byte_sender (
    input  wire             CLK,
    input  wire             RST_N,
    input  wire             send,
    input  wire             [char_pkg::BYTE_WIDTH-1:0] send_byte,
    input  wire             tx_busy,
    output logic            ready,
    output logic            done,
    output logic            de,
    output char_pkg::byte_t data
);

    typedef enum logic [1:0] {
        TX_IDLE      = 2'd0,
        TX_PRESENT   = 2'd1,
        TX_WAIT_FALL = 2'd2
    } tx_state_t;

    tx_state_t state;
    logic      busy_q;
    logic      busy_rise;
    logic      busy_fall;

    // ------------------------------------------------------------------------
    // Transmitter busy edges
    // ------------------------------------------------------------------------
    assign busy_rise = tx_busy & ~busy_q;
    assign busy_fall = ~tx_busy & busy_q;

    assign ready = (state == TX_IDLE);

    // ------------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state  <= TX_IDLE;
            busy_q <= 1'b0;
            de     <= 1'b0;
            done   <= 1'b0;
            data   <= char_pkg::IDLE_BYTE;
        end else begin
            busy_q <= tx_busy;
            done   <= 1'b0;
            case (state)
                TX_IDLE: begin
                    if (send) begin
                        data  <= send_byte;
                        de    <= 1'b1;
                        state <= TX_PRESENT;
                    end
                end
                TX_PRESENT: begin
                    // Hold de and data until the transmitter takes the byte
                    if (busy_rise) begin
                        de    <= 1'b0;
                        state <= TX_WAIT_FALL;
                    end
                end
                TX_WAIT_FALL: begin
                    if (busy_fall) begin
                        done  <= 1'b1;
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    de    <= 1'b0;
                    state <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/char_pkg.sv
// Serial byte type, character constants, hex character bundle and digit counter type

`default_nettype none

package char_pkg;

    localparam int BYTE_WIDTH = 8;

    typedef logic [BYTE_WIDTH-1:0] byte_t;

    // ASCII codes
    localparam byte_t CHAR_LF      = 8'h0A;
    localparam byte_t CHAR_DIGIT_0 = 8'h30;
    localparam byte_t CHAR_UPPER_A = 8'h41;

    // Data output before the first byte goes out
    localparam byte_t IDLE_BYTE = 8'hFF;

    // Widest hex field
    localparam int MAX_DIGITS = 7;

    // First character in the top byte, unused low bytes zero
    typedef logic [MAX_DIGITS*BYTE_WIDTH-1:0] hex_chars_t;

    // Characters left in a field, 0 to MAX_DIGITS
    typedef logic [$clog2(MAX_DIGITS+1)-1:0] digit_cnt_t;

endpackage

`default_nettype wire

// File: logic/eye_report_top.sv
// eye_report_top: hex encoders, report sequencer and byte sender

`timescale 1ns/1ps
`default_nettype none

module eye_report_top (
    input  wire                         CLK,
    input  wire                         RST_N,
    input  wire                         out_sel,
    input  wire meas_pkg::meas_fields_t fields,
    input  wire                         trig,
    input  wire                         tx_busy,
    output logic                        busy,
    output logic                        de,
    output char_pkg::byte_t             data
);

    char_pkg::hex_chars_t s_chars;
    char_pkg::hex_chars_t sx_chars;
    char_pkg::hex_chars_t sy_chars;
    char_pkg::hex_chars_t qsx_chars;
    char_pkg::hex_chars_t qsy_chars;
    logic                 send;
    char_pkg::byte_t      send_byte;
    logic                 ready;
    logic                 done;

    // ------------------------------------------------------------------------
    // Hex encoders
    // ------------------------------------------------------------------------
    hex_encoder #(
        .value_t (meas_pkg::sum_s_t),
        .DIGITS  (meas_pkg::S_DIGITS)
    ) u_enc_s (
        .CLK   (CLK),
        .RST_N (RST_N),
        .value (fields.sum_s),
        .chars (s_chars)
    );

    hex_encoder #(.value_t(meas_pkg::sum_xy_t), .DIGITS(meas_pkg::XY_DIGITS)) u_enc_sx (
        .CLK(CLK), .RST_N(RST_N), .value(fields.sum_sx), .chars(sx_chars)
    );

    hex_encoder #(.value_t(meas_pkg::sum_xy_t), .DIGITS(meas_pkg::XY_DIGITS)) u_enc_sy (
        .CLK(CLK), .RST_N(RST_N), .value(fields.sum_sy), .chars(sy_chars)
    );

    hex_encoder #(.value_t(meas_pkg::sum_xy_t), .DIGITS(meas_pkg::XY_DIGITS)) u_enc_qsx (
        .CLK(CLK), .RST_N(RST_N), .value(fields.quot_sx), .chars(qsx_chars)
    );

    hex_encoder #(.value_t(meas_pkg::sum_xy_t), .DIGITS(meas_pkg::XY_DIGITS)) u_enc_qsy (
        .CLK(CLK), .RST_N(RST_N), .value(fields.quot_sy), .chars(qsy_chars)
    );

    // ------------------------------------------------------------------------
    // Sequencing and transmitter hand-off
    // ------------------------------------------------------------------------
    report_sequencer u_seq (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .trig      (trig),
        .out_sel   (out_sel),
        .s_chars   (s_chars),
        .sx_chars  (sx_chars),
        .sy_chars  (sy_chars),
        .qsx_chars (qsx_chars),
        .qsy_chars (qsy_chars),
        .ready     (ready),
        .done      (done),
        .send      (send),
        .send_byte (send_byte),
        .busy      (busy)
    );

    byte_sender u_sender (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .send      (send),
        .send_byte (send_byte),
        .tx_busy   (tx_busy),
        .ready     (ready),
        .done      (done),
        .de        (de),
        .data      (data)
    );

endmodule

`default_nettype wire

// File: logic/hex_encoder.sv
// hex_encoder: registered binary to upper-case ASCII hex conversion

`timescale 1ns/1ps
`default_nettype none

module hex_encoder #(
    parameter type value_t = logic [27:0],
    parameter int  DIGITS  = 7
) (
    input  wire                  CLK,
    input  wire                  RST_N,
    input  wire value_t          value,
    output char_pkg::hex_chars_t chars
);

    logic [4*DIGITS-1:0]  digits_value;
    char_pkg::hex_chars_t next_chars;

    function automatic char_pkg::byte_t hex_char(input logic [3:0] nibble);
        if (nibble < 4'd10) begin
            return char_pkg::CHAR_DIGIT_0 + char_pkg::byte_t'(nibble);
        end
        return char_pkg::CHAR_UPPER_A + char_pkg::byte_t'(nibble - 4'd10);
    endfunction

    // Value widened or trimmed to whole nibbles
    assign digits_value = (4*DIGITS)'(value);

    // Most significant nibble into the top byte
    always_comb begin
        next_chars = '0;
        for (int i = 0; i < DIGITS; i++) begin
            next_chars[char_pkg::BYTE_WIDTH*(char_pkg::MAX_DIGITS-1-i) +: char_pkg::BYTE_WIDTH]
                = hex_char(digits_value[4*(DIGITS-1-i) +: 4]);
        end
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            chars <= '0;
        end else begin
            chars <= next_chars;
        end
    end

endmodule

`default_nettype wire

// File: logic/meas_pkg.sv
// Measurement field widths, digit counts, field selector and measurement bundle

`default_nettype none

package meas_pkg;

    // ------------------------------------------------------------------------
    // Field widths
    // ------------------------------------------------------------------------
    localparam int SUM_S_WIDTH  = 20;
    localparam int SUM_XY_WIDTH = 28;

    typedef logic [SUM_S_WIDTH-1:0]  sum_s_t;
    typedef logic [SUM_XY_WIDTH-1:0] sum_xy_t;

    // ------------------------------------------------------------------------
    // Report layout
    // ------------------------------------------------------------------------
    localparam int S_DIGITS     = 5;
    localparam int XY_DIGITS    = 7;
    // Count field, two coordinate fields, line feed
    localparam int REPORT_BYTES = S_DIGITS + 2 * XY_DIGITS + 1;

    // Field order within one report
    typedef enum logic [1:0] {
        FIELD_COUNT    = 2'd0,
        FIELD_COORD_1  = 2'd1,
        FIELD_COORD_2  = 2'd2,
        FIELD_LINE_END = 2'd3
    } field_t;

    // Measurement results from the centroid stage
    typedef struct packed {
        sum_s_t  sum_s;
        sum_xy_t sum_sx;
        sum_xy_t sum_sy;
        sum_xy_t quot_sx;
        sum_xy_t quot_sy;
    } meas_fields_t;

endpackage

`default_nettype wire

// File: logic/report_sequencer.sv
// report_sequencer: trigger edge detection and field and character sequencing

`timescale 1ns/1ps
`default_nettype none

module report_sequencer (
    input  wire                  CLK,
    input  wire                  RST_N,
    input  wire                  trig,
    input  wire                  out_sel,
    input  wire                  [$bits(char_pkg::hex_chars_t)-1:0] s_chars,
    input  wire                  [$bits(char_pkg::hex_chars_t)-1:0] sx_chars,
    input  wire                  [$bits(char_pkg::hex_chars_t)-1:0] sy_chars,
    input  wire                  [$bits(char_pkg::hex_chars_t)-1:0] qsx_chars,
    input  wire                  [$bits(char_pkg::hex_chars_t)-1:0] qsy_chars,
    input  wire                  ready,
    input  wire                  done,
    output logic                 send,
    output char_pkg::byte_t      send_byte,
    output logic                 busy
);

    logic                 trig_d1;
    logic                 trig_d2;
    logic                 start;
    meas_pkg::field_t     field;
    meas_pkg::field_t     next_field;
    char_pkg::digit_cnt_t remaining;
    char_pkg::digit_cnt_t next_field_count;
    char_pkg::hex_chars_t next_field_chars;
    char_pkg::hex_chars_t shift_reg;
    logic                 wait_done;
    logic                 sel_q;
    logic                 last_char;
    logic                 char_done;

    // ------------------------------------------------------------------------
    // Trigger delay and rising edge
    // ------------------------------------------------------------------------
    assign start = trig_d1 & ~trig_d2;

    assign last_char = (remaining == char_pkg::digit_cnt_t'(1));
    assign char_done = busy & wait_done & done;

    // Top byte goes out first
    assign send_byte = shift_reg[$bits(char_pkg::hex_chars_t)-1 -: char_pkg::BYTE_WIDTH];

    // Field that follows the current one, with its characters
    always_comb begin
        next_field_chars = '0;
        case (field)
            meas_pkg::FIELD_COUNT: begin
                next_field       = meas_pkg::FIELD_COORD_1;
                next_field_count = char_pkg::digit_cnt_t'(meas_pkg::XY_DIGITS);
                next_field_chars = out_sel ? qsx_chars : sx_chars;
            end
            meas_pkg::FIELD_COORD_1: begin
                next_field       = meas_pkg::FIELD_COORD_2;
                next_field_count = char_pkg::digit_cnt_t'(meas_pkg::XY_DIGITS);
                // Same source as the first coordinate
                next_field_chars = sel_q ? qsy_chars : sy_chars;
            end
            meas_pkg::FIELD_COORD_2: begin
                next_field       = meas_pkg::FIELD_LINE_END;
                next_field_count = char_pkg::digit_cnt_t'(1);
                next_field_chars[$bits(char_pkg::hex_chars_t)-1 -: char_pkg::BYTE_WIDTH]
                    = char_pkg::CHAR_LF;
            end
            default: begin
                next_field       = meas_pkg::FIELD_COUNT;
                next_field_count = char_pkg::digit_cnt_t'(meas_pkg::S_DIGITS);
                next_field_chars = s_chars;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            trig_d1   <= 1'b0;
            trig_d2   <= 1'b0;
            busy      <= 1'b0;
            field     <= meas_pkg::FIELD_COUNT;
            remaining <= '0;
            wait_done <= 1'b0;
            sel_q     <= 1'b0;
            send      <= 1'b0;
        end else begin
            trig_d1 <= trig;
            trig_d2 <= trig_d1;
            send    <= 1'b0;
            if (!busy) begin
                // Edges during a report are dropped here
                if (start) begin
                    busy      <= 1'b1;
                    field     <= meas_pkg::FIELD_COUNT;
                    remaining <= char_pkg::digit_cnt_t'(meas_pkg::S_DIGITS);
                    wait_done <= 1'b0;
                end
            end else if (!wait_done) begin
                if (ready) begin
                    send      <= 1'b1;
                    wait_done <= 1'b1;
                end
            end else if (done) begin
                wait_done <= 1'b0;
                if (!last_char) begin
                    remaining <= remaining - char_pkg::digit_cnt_t'(1);
                end else if (field == meas_pkg::FIELD_LINE_END) begin
                    busy <= 1'b0;
                end else begin
                    field     <= next_field;
                    remaining <= next_field_count;
                    if (field == meas_pkg::FIELD_COUNT) begin
                        sel_q <= out_sel;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Character shift register
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (!busy && start) begin
            shift_reg <= s_chars;
        end else if (char_done) begin
            if (last_char) begin
                shift_reg <= next_field_chars;
            end else begin
                shift_reg <= shift_reg << char_pkg::BYTE_WIDTH;
            end
        end
    end

endmodule

`default_nettype wire

// File: sources.f
logic/meas_pkg.sv
logic/char_pkg.sv
logic/hex_encoder.sv
logic/byte_sender.sv
logic/report_sequencer.sv
logic/eye_report_top.sv
dv/tx_busy_model.sv
dv/tb_eye_report.sv
